// ==== hdl/uart_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_axil_regs
	import uart_line_pkg::*;
	import uart_regs_pkg::*;
(
	input  wire         CLK,
	input  wire         reset,
	input  wire  [3:0]  axil_awaddr,
	input  wire         axil_awvalid,
	output logic        axil_awready,
	input  wire  [31:0] axil_wdata,
	input  wire         axil_wvalid,
	output logic        axil_wready,
	output logic [1:0]  axil_bresp,
	output logic        axil_bvalid,
	input  wire         axil_bready,
	input  wire  [3:0]  axil_araddr,
	input  wire         axil_arvalid,
	output logic        axil_arready,
	output logic [31:0] axil_rdata,
	output logic [1:0]  axil_rresp,
	output logic        axil_rvalid,
	input  wire         axil_rready,
	input  rx_byte_t    head,
	input  wire         empty,
	input  wire         full,
	input  wire         overrun,
	input  wire         frame_error,
	output logic        pop,
	output logic        clear
);

	function automatic reg_sel_t decode_addr(input logic [3:0] addr);
		case (addr)
			`UART_REG_DATA:   return REG_DATA;
			`UART_REG_STATUS: return REG_STATUS;
			`UART_REG_CTRL:   return REG_CTRL;
			default:          return REG_NONE;
		endcase
	endfunction

	logic        wr_ready;
	logic        wr_fire;
	logic        rd_fire;
	reg_sel_t    wr_sel;
	reg_sel_t    rd_sel;
	axi_resp_t   bresp_q;
	axi_resp_t   rresp_q;
	logic [31:0] rd_word;

	assign wr_sel = decode_addr(axil_awaddr);
	assign rd_sel = decode_addr(axil_araddr);

	////////////////////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////////////////////

	// Address and data accepted together
	assign axil_awready = wr_ready;
	assign axil_wready  = wr_ready;
	assign wr_fire      = wr_ready && axil_awvalid && axil_wvalid;

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ready    <= 1'b0;
			axil_bvalid <= 1'b0;
			clear       <= 1'b0;
		end else begin
			// One-cycle ready, blocked while a response waits
			wr_ready <= axil_awvalid && axil_wvalid && !axil_bvalid && !wr_ready;
			// Clear strobe lines up with bvalid rising
			clear    <= wr_fire && (wr_sel == REG_CTRL) && axil_wdata[0];
			if (wr_fire) begin
				axil_bvalid <= 1'b1;
			end else if (axil_bready) begin
				axil_bvalid <= 1'b0;
			end
		end
	end

	// DATA and STATUS writes are dropped but still OKAY
	always_ff @(posedge CLK) begin
		if (wr_fire) begin
			bresp_q <= (wr_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign axil_bresp = bresp_q;

	////////////////////////////////////////////////////////////////////////////
	// Read channel
	////////////////////////////////////////////////////////////////////////////

	assign rd_fire = axil_arready && axil_arvalid;

	// Pop on accept, never on an empty FIFO
	assign pop = rd_fire && (rd_sel == REG_DATA) && !empty;

	// Read mux, empty DATA reads as zero
	always_comb begin
		rd_word = '0;
		unique case (rd_sel)
			REG_DATA: begin
				if (!empty) begin
					rd_word = {{(32 - `UART_DATA_BITS){1'b0}}, head};
				end
			end
			REG_STATUS: rd_word = {28'b0, overrun, frame_error, full, empty};
			REG_CTRL:   rd_word = '0;
			REG_NONE:   rd_word = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			axil_arready <= 1'b0;
			axil_rvalid  <= 1'b0;
		end else begin
			axil_arready <= axil_arvalid && !axil_rvalid && !axil_arready;
			if (rd_fire) begin
				axil_rvalid <= 1'b1;
			end else if (axil_rready) begin
				axil_rvalid <= 1'b0;
			end
		end
	end

	// Payload latched on accept, held under back-pressure
	always_ff @(posedge CLK) begin
		if (rd_fire) begin
			axil_rdata <= rd_word;
			rresp_q    <= (rd_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign axil_rresp = rresp_q;

	rdata_hold: assert property (
		@(posedge CLK) disable iff (reset)
		axil_rvalid && !axil_rready |=> axil_rvalid && $stable(axil_rdata)
	);

	bvalid_hold: assert property (
		@(posedge CLK) disable iff (reset)
		axil_bvalid && !axil_bready |=> axil_bvalid && $stable(axil_bresp)
	);

endmodule

`default_nettype wire

// ==== hdl/uart_bit_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_bit_receiver
	import uart_line_pkg::*;
(
	input  wire       CLK,
	input  wire       reset,
	input  wire       serial_in,
	input  wire       clear,
	output rx_byte_t  rx_data,
	output logic      rx_push,
	output logic      frame_error
);

	////////////////////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////////////////////

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int PW   = $clog2(CLKS);
	localparam int GW   = $clog2(`UART_GUARD_BITS + 1);
	localparam int BW   = $clog2(`UART_DATA_BITS + 2);

	// Prescaler value that raises the bit tick
	localparam logic [PW-1:0] TICK_LAST  = PW'(CLKS - 1);
	// Load on the start edge, so the first tick lands mid-bit
	localparam logic [PW-1:0] HALF_LOAD  = PW'(CLKS / 2 - 1);
	localparam logic [GW-1:0] GUARD_LAST = GW'(`UART_GUARD_BITS - 1);
	// Bit index 0 is the start bit, the stop bit follows the data
	localparam logic [BW-1:0] STOP_IDX   = BW'(`UART_DATA_BITS + 1);

	////////////////////////////////////////////////////////////////////////////
	// Signals
	////////////////////////////////////////////////////////////////////////////

	rx_state_t        state;
	logic [1:0]       sync_q;
	logic             line_s;
	logic [PW-1:0]    prescale;
	logic             tick;
	logic [GW-1:0]    guard_cnt;
	logic [BW-1:0]    bit_cnt;
	rx_byte_t         data_sr;

	// Two-flop synchronizer, idles high like the line
	always_ff @(posedge CLK) begin
		if (reset) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], serial_in};
		end
	end

	assign line_s = sync_q[1];
	assign tick   = (prescale == TICK_LAST);

	////////////////////////////////////////////////////////////////////////////
	// Receive FSM with prescaler, guard count and bit index
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (reset) begin
			state     <= RX_INIT;
			prescale  <= '0;
			guard_cnt <= '0;
			bit_cnt   <= '0;
			rx_push   <= 1'b0;
		end else begin
			// Free running bit-time prescaler, overridden below
			prescale <= tick ? '0 : prescale + 1'b1;
			rx_push  <= 1'b0;
			if (clear) begin
				// Software clear restarts the line guard from any state
				state     <= RX_INIT;
				prescale  <= '0;
				guard_cnt <= '0;
				bit_cnt   <= '0;
			end else begin
				unique case (state)
					RX_ERROR: begin
						state <= RX_ERROR;
					end
					RX_INIT: begin
						if (!line_s) begin
							// Any low restarts the quiet-line count
							guard_cnt <= '0;
							prescale  <= '0;
						end else if (tick) begin
							if (guard_cnt == GUARD_LAST) begin
								guard_cnt <= '0;
								state     <= RX_IDLE;
							end else begin
								guard_cnt <= guard_cnt + 1'b1;
							end
						end
					end
					RX_IDLE: begin
						// Falling edge of the start bit
						if (!line_s) begin
							prescale <= HALF_LOAD;
							bit_cnt  <= '0;
							state    <= RX_READ;
						end
					end
					RX_READ: begin
						if (tick) begin
							if (bit_cnt == '0) begin
								// Start bit gone high by mid-bit, a glitch
								if (line_s) begin
									state <= RX_IDLE;
								end else begin
									bit_cnt <= bit_cnt + 1'b1;
								end
							end else if (bit_cnt == STOP_IDX) begin
								bit_cnt <= '0;
								if (line_s) begin
									rx_push <= 1'b1;
									state   <= RX_IDLE;
								end else begin
									state <= RX_ERROR;
								end
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				endcase
			end
		end
	end

	// Data bits arrive LSB first, shifted in from the top
	always_ff @(posedge CLK) begin
		if (state == RX_READ && tick && bit_cnt != '0 && bit_cnt != STOP_IDX) begin
			data_sr <= {line_s, data_sr[`UART_DATA_BITS-1:1]};
		end
	end

	assign rx_data     = data_sr;
	assign frame_error = (state == RX_ERROR);

	// A byte is only pushed on the way out of a frame
	push_from_read: assert property (
		@(posedge CLK) disable iff (reset)
		rx_push |-> $past(state) == RX_READ
	);

endmodule

`default_nettype wire

// ==== hdl/uart_line_pkg.sv ====
`default_nettype none

`include "uart_rx_macros.svh"

package uart_line_pkg;

	// Bit receiver states
	typedef enum logic [1:0] {
		// Sticky framing error left only by a clear
		RX_ERROR = 2'b00,
		// Line guard waits for a quiet high line
		RX_INIT  = 2'b01,
		// Armed and looking for a start bit
		RX_IDLE  = 2'b10,
		// Start, data and stop bit sampling
		RX_READ  = 2'b11
	} rx_state_t;

	// One received data byte
	typedef logic [`UART_DATA_BITS-1:0] rx_byte_t;

endpackage

`default_nettype wire

// ==== hdl/uart_regs_pkg.sv ====
`default_nettype none

package uart_regs_pkg;

	// Result of the register address decode
	typedef enum logic [1:0] {
		// Receive data, pops the FIFO on read
		REG_DATA   = 2'b00,
		// Flags, read only
		REG_STATUS = 2'b01,
		// Error and overrun clear, write only
		REG_CTRL   = 2'b10,
		// Outside the map
		REG_NONE   = 2'b11
	} reg_sel_t;

	// AXI4-Lite response codes in use
	// EXOKAY and DECERR are never returned by this slave
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

// ==== hdl/uart_rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_fifo
	import uart_line_pkg::*;
#(
	parameter int AW = `UART_FIFO_AW
) (
	input  wire       CLK,
	input  wire       reset,
	input  wire       push,
	input  rx_byte_t  data_in,
	input  wire       pop,
	input  wire       clear,
	output rx_byte_t  head,
	output logic      empty,
	output logic      full,
	output logic      overrun
);

	localparam int DEPTH = 1 << AW;
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

	rx_byte_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	// Writes into a full buffer are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == FULL_COUNT);

	// Show-ahead head, valid whenever not empty
	assign head = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers, count and overrun
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			unique case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// A fresh drop outranks a clear in the same cycle
			if (push && full) begin
				overrun <= 1'b1;
			end else if (clear) begin
				overrun <= 1'b0;
			end
		end
	end

	// Decoder must only pop a non-empty FIFO
	no_pop_empty: assert property (
		@(posedge CLK) disable iff (reset)
		pop |-> !empty
	);

	count_bound: assert property (
		@(posedge CLK) disable iff (reset)
		count <= FULL_COUNT
	);

endmodule

`default_nettype wire

// ==== hdl/uart_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_top
	import uart_line_pkg::*;
(
	input  wire         CLK,
	input  wire         reset,
	input  wire         serial_in,
	input  wire  [3:0]  axil_awaddr,
	input  wire         axil_awvalid,
	output logic        axil_awready,
	input  wire  [31:0] axil_wdata,
	input  wire         axil_wvalid,
	output logic        axil_wready,
	output logic [1:0]  axil_bresp,
	output logic        axil_bvalid,
	input  wire         axil_bready,
	input  wire  [3:0]  axil_araddr,
	input  wire         axil_arvalid,
	output logic        axil_arready,
	output logic [31:0] axil_rdata,
	output logic [1:0]  axil_rresp,
	output logic        axil_rvalid,
	input  wire         axil_rready
);

	// Receiver to FIFO
	rx_byte_t rx_data;
	logic     rx_push;
	// FIFO to decoder
	rx_byte_t head;
	logic     empty;
	logic     full;
	logic     overrun;
	// Decoder strobes and receiver status
	logic     pop;
	logic     clear;
	logic     frame_error;

	////////////////////////////////////////////////////////////////////////////
	// Execute, result, decode
	////////////////////////////////////////////////////////////////////////////

	uart_bit_receiver uart_bit_receiver_i (
		.CLK         (CLK),
		.reset       (reset),
		.serial_in   (serial_in),
		.clear       (clear),
		.rx_data     (rx_data),
		.rx_push     (rx_push),
		.frame_error (frame_error)
	);

	uart_rx_fifo #(
		.AW (`UART_FIFO_AW)
	) uart_rx_fifo_i (
		.CLK     (CLK),
		.reset   (reset),
		.push    (rx_push),
		.data_in (rx_data),
		.pop     (pop),
		.clear   (clear),
		.head    (head),
		.empty   (empty),
		.full    (full),
		.overrun (overrun)
	);

	uart_axil_regs uart_axil_regs_i (
		.CLK          (CLK),
		.reset        (reset),
		.axil_awaddr  (axil_awaddr),
		.axil_awvalid (axil_awvalid),
		.axil_awready (axil_awready),
		.axil_wdata   (axil_wdata),
		.axil_wvalid  (axil_wvalid),
		.axil_wready  (axil_wready),
		.axil_bresp   (axil_bresp),
		.axil_bvalid  (axil_bvalid),
		.axil_bready  (axil_bready),
		.axil_araddr  (axil_araddr),
		.axil_arvalid (axil_arvalid),
		.axil_arready (axil_arready),
		.axil_rdata   (axil_rdata),
		.axil_rresp   (axil_rresp),
		.axil_rvalid  (axil_rvalid),
		.axil_rready  (axil_rready),
		.head         (head),
		.empty        (empty),
		.full         (full),
		.overrun      (overrun),
		.frame_error  (frame_error),
		.pop          (pop),
		.clear        (clear)
	);

endmodule

`default_nettype wire

// ==== include/uart_rx_macros.svh ====
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame and timing
////////////////////////////////////////////////////////////////////////////

// Data bits per frame, no parity
`define UART_DATA_BITS 8

// CLK cycles in one bit time
// Kept short so that a frame takes few cycles
`define UART_CLKS_PER_BIT 16

// Bit times of steady high line before the receiver arms
`define UART_GUARD_BITS 10

////////////////////////////////////////////////////////////////////////////
// Receive FIFO and register map
////////////////////////////////////////////////////////////////////////////

// Default FIFO address width, 16 entries
`define UART_FIFO_AW 4

// Byte offsets on the 4-bit AXI4-Lite address
`define UART_REG_DATA 4'h0
`define UART_REG_STATUS 4'h4
`define UART_REG_CTRL 4'h8

`endif

// ==== sources.f ====
+incdir+include
hdl/uart_line_pkg.sv
hdl/uart_regs_pkg.sv
hdl/uart_bit_receiver.sv
hdl/uart_rx_fifo.sv
hdl/uart_axil_regs.sv
hdl/uart_rx_top.sv
testbench/uart_rx_tb.sv

// ==== testbench/uart_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_tb
	import uart_line_pkg::*;
	import uart_regs_pkg::*;
();

	localparam int CLKS     = `UART_CLKS_PER_BIT;
	localparam int DEPTH    = 1 << `UART_FIFO_AW;
	localparam int WAIT_MAX = 200;
	localparam int POLL_MAX = 100;
	// Quiet line after reset or clear, plus synchronizer slack
	localparam int GUARD_CYCLES = (`UART_GUARD_BITS + 1) * CLKS + 8;
	localparam logic [3:0] BAD_ADDR = 4'hC;

	logic        CLK;
	logic        reset;
	logic        serial_in;
	logic [3:0]  axil_awaddr;
	logic        axil_awvalid;
	logic        axil_awready;
	logic [31:0] axil_wdata;
	logic        axil_wvalid;
	logic        axil_wready;
	logic [1:0]  axil_bresp;
	logic        axil_bvalid;
	logic        axil_bready;
	logic [3:0]  axil_araddr;
	logic        axil_arvalid;
	logic        axil_arready;
	logic [31:0] axil_rdata;
	logic [1:0]  axil_rresp;
	logic        axil_rvalid;
	logic        axil_rready;

	// Reference model of FIFO contents and sticky flags
	rx_byte_t model_q[$];
	bit       model_err;
	bit       model_ovr;

	// Pending comparisons posted by the stimulus
	string       name_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] act_q[$];
	event        posted;

	int     mismatch_count;
	int     timeout_count;
	int     check_count;
	integer seed;

	uart_rx_top uart_rx_top_i (
		.CLK          (CLK),
		.reset        (reset),
		.serial_in    (serial_in),
		.axil_awaddr  (axil_awaddr),
		.axil_awvalid (axil_awvalid),
		.axil_awready (axil_awready),
		.axil_wdata   (axil_wdata),
		.axil_wvalid  (axil_wvalid),
		.axil_wready  (axil_wready),
		.axil_bresp   (axil_bresp),
		.axil_bvalid  (axil_bvalid),
		.axil_bready  (axil_bready),
		.axil_araddr  (axil_araddr),
		.axil_arvalid (axil_arvalid),
		.axil_arready (axil_arready),
		.axil_rdata   (axil_rdata),
		.axil_rresp   (axil_rresp),
		.axil_rvalid  (axil_rvalid),
		.axil_rready  (axil_rready)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// STATUS word from the model depth and flags
	function automatic logic [31:0] expected_status(input int n, input bit err, input bit ovr);
		logic [31:0] s;
		s    = '0;
		s[0] = (n == 0);
		s[1] = (n >= DEPTH);
		s[2] = err;
		s[3] = ovr;
		return s;
	endfunction

	// Frames are ignored while the receiver sits in error
	function automatic void model_frame(input rx_byte_t data, input bit stop);
		if (!model_err) begin
			if (!stop) begin
				model_err = 1'b1;
			end else if (model_q.size() < DEPTH) begin
				model_q.push_back(data);
			end else begin
				model_ovr = 1'b1;
			end
		end
	endfunction

	task automatic post_check(input string name, input logic [31:0] exp, input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
		-> posted;
	endtask

	// Compare process drains everything posted so far
	initial begin : compare_proc
		string       name;
		logic [31:0] e;
		logic [31:0] a;
		forever begin
			@(posted);
			while (act_q.size() > 0) begin
				name = name_q.pop_front();
				e    = exp_q.pop_front();
				a    = act_q.pop_front();
				check_count++;
				if (a !== e) begin
					mismatch_count++;
					$display("Mismatch %s: expected 0x%h, actual 0x%h", name, e, a);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Serial and AXI4-Lite drivers
	////////////////////////////////////////////////////////////////////////////

	// Start, eight data bits LSB first, chosen stop level, then idle
	task automatic send_frame(input rx_byte_t data, input bit stop);
		int i;
		serial_in <= 1'b0;
		repeat (CLKS) @(posedge CLK);
		for (i = 0; i < `UART_DATA_BITS; i++) begin
			serial_in <= data[i];
			repeat (CLKS) @(posedge CLK);
		end
		serial_in <= stop;
		repeat (CLKS) @(posedge CLK);
		// Idle tail covers the push latency
		serial_in <= 1'b1;
		repeat (2 * CLKS) @(posedge CLK);
		model_frame(data, stop);
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
			output logic [1:0] resp);
		int         n;
		logic [1:0] first;
		resp = 2'bxx;
		axil_awaddr  <= addr;
		axil_awvalid <= 1'b1;
		axil_wdata   <= data;
		axil_wvalid  <= 1'b1;
		axil_bready  <= (hold == 0);
		n = 0;
		@(posedge CLK);
		while (!axil_awready && n < WAIT_MAX) begin
			@(posedge CLK);
			n++;
		end
		if (!axil_awready) begin
			timeout_count++;
			$display("Timeout: write to address 0x%h was never accepted", addr);
		end else begin
			// Data channel is taken in the same cycle as the address
			post_check("axil_wready", 32'h1, axil_wready);
		end
		axil_awvalid <= 1'b0;
		axil_wvalid  <= 1'b0;
		n = 0;
		@(posedge CLK);
		while (!axil_bvalid && n < WAIT_MAX) begin
			@(posedge CLK);
			n++;
		end
		if (!axil_bvalid) begin
			timeout_count++;
			$display("Timeout: no write response for address 0x%h", addr);
		end else begin
			first = axil_bresp;
			if (hold > 0) begin
				// Response must hold while bready is low
				repeat (hold) begin
					@(posedge CLK);
					post_check("axil_bvalid (held)", 32'h1, axil_bvalid);
					post_check("axil_bresp (held)", first, axil_bresp);
				end
				axil_bready <= 1'b1;
				@(posedge CLK);
				post_check("axil_bvalid (release)", 32'h1, axil_bvalid);
				@(posedge CLK);
				post_check("axil_bvalid (after transfer)", 32'h0, axil_bvalid);
			end
			resp = first;
		end
		axil_bready <= 1'b1;
	endtask

	task automatic axil_read(input logic [3:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		int          n;
		logic [31:0] first;
		data = 'x;
		resp = 2'bxx;
		axil_araddr  <= addr;
		axil_arvalid <= 1'b1;
		axil_rready  <= (hold == 0);
		n = 0;
		@(posedge CLK);
		while (!axil_arready && n < WAIT_MAX) begin
			@(posedge CLK);
			n++;
		end
		if (!axil_arready) begin
			timeout_count++;
			$display("Timeout: read from address 0x%h was never accepted", addr);
		end
		axil_arvalid <= 1'b0;
		n = 0;
		@(posedge CLK);
		while (!axil_rvalid && n < WAIT_MAX) begin
			@(posedge CLK);
			n++;
		end
		if (!axil_rvalid) begin
			timeout_count++;
			$display("Timeout: no read data for address 0x%h", addr);
		end else begin
			first = axil_rdata;
			resp  = axil_rresp;
			if (hold > 0) begin
				repeat (hold) begin
					@(posedge CLK);
					post_check("axil_rvalid (held)", 32'h1, axil_rvalid);
					post_check("axil_rdata (held)", first, axil_rdata);
				end
				axil_rready <= 1'b1;
				@(posedge CLK);
				post_check("axil_rvalid (release)", 32'h1, axil_rvalid);
				@(posedge CLK);
				post_check("axil_rvalid (after transfer)", 32'h0, axil_rvalid);
			end
			data = first;
		end
		axil_rready <= 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checked register accesses
	////////////////////////////////////////////////////////////////////////////

	// Expected byte comes off the model queue or is zero when empty
	task automatic check_data_read(input int hold);
		logic [31:0] data;
		logic [1:0]  resp;
		logic [31:0] exp;
		exp = '0;
		if (model_q.size() > 0) begin
			exp = model_q.pop_front();
		end
		axil_read(`UART_REG_DATA, hold, data, resp);
		post_check("axil_rdata (DATA)", exp, data);
		post_check("axil_rresp (DATA)", RESP_OKAY, resp);
	endtask

	task automatic check_status_read();
		logic [31:0] data;
		logic [1:0]  resp;
		logic [31:0] exp;
		exp = expected_status(model_q.size(), model_err, model_ovr);
		axil_read(`UART_REG_STATUS, 0, data, resp);
		post_check("axil_rdata (STATUS)", exp, data);
		post_check("axil_rresp (STATUS)", RESP_OKAY, resp);
	endtask

	task automatic check_bad_read(input int hold);
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(BAD_ADDR, hold, data, resp);
		post_check("axil_rdata (unmapped)", 32'h0, data);
		post_check("axil_rresp (unmapped)", RESP_SLVERR, resp);
	endtask

	task automatic check_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
			input axi_resp_t exp);
		logic [1:0] resp;
		axil_write(addr, data, hold, resp);
		post_check("axil_bresp", exp, resp);
	endtask

	// CTRL clear drops error and overrun and restarts the line guard
	task automatic clear_errors();
		check_write(`UART_REG_CTRL, 32'h1, 0, RESP_OKAY);
		model_err = 1'b0;
		model_ovr = 1'b0;
	endtask

	// Poll STATUS until a byte sits in the FIFO
	task automatic wait_not_empty();
		logic [31:0] data;
		logic [1:0]  resp;
		int          n;
		n = 0;
		axil_read(`UART_REG_STATUS, 0, data, resp);
		while (data[0] !== 1'b0 && n < POLL_MAX) begin
			axil_read(`UART_REG_STATUS, 0, data, resp);
			n++;
		end
		if (data[0] !== 1'b0) begin
			timeout_count++;
			$display("Timeout: FIFO never reported a received byte");
		end
	endtask

	function automatic rx_byte_t random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		int i;
		seed           = 32'hf9696e20;
		mismatch_count = 0;
		timeout_count  = 0;
		check_count    = 0;
		model_err      = 1'b0;
		model_ovr      = 1'b0;
		reset          = 1'b1;
		serial_in      = 1'b1;
		axil_awaddr    = '0;
		axil_awvalid   = 1'b0;
		axil_wdata     = '0;
		axil_wvalid    = 1'b0;
		axil_bready    = 1'b1;
		axil_araddr    = '0;
		axil_arvalid   = 1'b0;
		axil_rready    = 1'b1;
		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);
		post_check("axil_awready (reset)", 32'h0, axil_awready);
		post_check("axil_wready (reset)", 32'h0, axil_wready);
		post_check("axil_arready (reset)", 32'h0, axil_arready);
		post_check("axil_bvalid (reset)", 32'h0, axil_bvalid);
		post_check("axil_rvalid (reset)", 32'h0, axil_rvalid);

		// After reset only empty is set and DATA reads zero
		repeat (GUARD_CYCLES) @(posedge CLK);
		check_status_read();
		check_data_read(0);

		// Byte order with reads every few frames
		for (i = 0; i < 20; i++) begin
			send_frame(random_byte(), 1'b1);
			if (i % 3 != 1) begin
				wait_not_empty();
				while (model_q.size() > 0) begin
					check_data_read(0);
				end
			end
		end
		while (model_q.size() > 0) begin
			check_data_read(0);
		end
		check_status_read();

		// Sticky framing error drops the next frame
		send_frame(random_byte(), 1'b0);
		check_status_read();
		send_frame(random_byte(), 1'b1);
		check_status_read();
		clear_errors();
		repeat (GUARD_CYCLES) @(posedge CLK);
		send_frame(random_byte(), 1'b1);
		wait_not_empty();
		check_data_read(0);
		check_status_read();

		// Seventeen frames into sixteen entries
		for (i = 0; i < DEPTH + 1; i++) begin
			send_frame(random_byte(), 1'b1);
		end
		check_status_read();
		while (model_q.size() > 0) begin
			check_data_read(0);
		end
		check_status_read();
		clear_errors();
		check_status_read();

		// Unmapped address and back-pressure
		check_bad_read(0);
		check_write(BAD_ADDR, 32'h1, 0, RESP_SLVERR);
		check_write(BAD_ADDR, 32'h1, 5, RESP_SLVERR);
		check_write(`UART_REG_STATUS, 32'hf, 4, RESP_OKAY);
		check_status_read();
		repeat (GUARD_CYCLES) @(posedge CLK);
		send_frame(random_byte(), 1'b1);
		wait_not_empty();
		check_data_read(6);
		check_status_read();
		check_bad_read(3);

		repeat (4) @(posedge CLK);
		$display("Checks %0d, mismatches %0d, timeouts %0d",
			check_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0 && check_count > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
